// File: hw/map_pkg.sv
/*
 * widths of the two-level virtual memory map
 * virtual address fields, level-2 entry access bits
 * vector typedefs for addresses, map indices and map entries
 */

package map_pkg;

   localparam int VADDR_W  = 24;
   localparam int L1_IDX_W = 11;
   localparam int L1_ENT_W = 5;
   localparam int L2_IDX_W = 10;
   localparam int L2_ENT_W = 24;
   localparam int PAGE_W   = 14;
   localparam int OFFSET_W = 8;
   localparam int PADDR_W  = 22;

   // vaddr bits 12..8 join the level-1 entry
   localparam int L2_FIELD_W   = L2_IDX_W - L1_ENT_W;
   localparam int L2_FIELD_LSB = OFFSET_W;
   localparam int L1_FIELD_LSB = L2_FIELD_LSB + L2_FIELD_W; // bits 23..13

   // level-2 entry layout, page sits in the low bits
   localparam int L2_VALID_BIT = 23;
   localparam int L2_WPERM_BIT = 22;

   typedef logic [VADDR_W-1:0]  vaddr_t;
   typedef logic [PADDR_W-1:0]  paddr_t;
   typedef logic [L1_IDX_W-1:0] l1_idx_t;
   typedef logic [L1_ENT_W-1:0] l1_ent_t;
   typedef logic [L2_IDX_W-1:0] l2_idx_t;
   typedef logic [L2_ENT_W-1:0] l2_ent_t;
   typedef logic [PAGE_W-1:0]   page_t;
   typedef logic [OFFSET_W-1:0] offset_t;

endpackage

// File: hw/map_req_pkg.sv
/*
 * request side of the virtual memory map
 * operation and fault encodings
 * request, response and pipeline stage records
 */

package map_req_pkg;

   typedef enum logic [1:0]
   {
      A_XLATE = 2'd0,
      A_WR_L1 = 2'd1,
      A_WR_L2 = 2'd2  // written through the level-1 pointer
   } a_op_e;

   typedef enum logic [1:0]
   {
      B_RD_L1 = 2'd0,
      B_WR_L1 = 2'd1,
      B_RD_L2 = 2'd2,
      B_WR_L2 = 2'd3
   } b_op_e;

   typedef enum logic [1:0]
   {
      F_NONE       = 2'd0,
      F_INVALID    = 2'd1,
      F_WRITE_PROT = 2'd2
   } fault_e;

   // processor channel
   typedef struct packed
   {
      logic             valid;
      a_op_e            op;
      logic             write;  // translation is for a store
      map_pkg::vaddr_t  vaddr;
      map_pkg::l2_ent_t wdata;
   } map_a_req_t;

   // maintenance channel, level-2 uses the low addr bits
   typedef struct packed
   {
      logic             valid;
      b_op_e            op;
      map_pkg::l1_idx_t addr;
      map_pkg::l2_ent_t wdata;
   } map_b_req_t;

   typedef struct packed
   {
      logic            valid;
      fault_e          fault;
      map_pkg::paddr_t paddr;
   } map_xlate_rsp_t;

   typedef struct packed
   {
      logic             valid;
      map_pkg::l2_ent_t rdata;
   } map_b_rsp_t;

   typedef struct packed
   {
      logic             valid;
      a_op_e            op;
      logic             write;
      map_pkg::vaddr_t  vaddr;
      map_pkg::l2_ent_t wdata;
   } map_s1_t;

   typedef struct packed
   {
      logic             valid;
      logic             write;
      map_pkg::offset_t offset;
   } map_s2_t;

   typedef struct packed
   {
      logic valid;
      logic sel_l2;
   } map_b_pend_t;

endpackage

// File: hw/part_2kx5dpram.sv
/*
 * level-1 map RAM, 2048 x 5
 * two synchronous ports, port a wins a write collision
 * registered reads that hold while rden is low
 */

`timescale 1ns/1ps

module part_2kx5dpram
(
   input  logic             reset,
   input  logic             clk_a,
   input  map_pkg::l1_idx_t address_a,
   input  map_pkg::l1_idx_t address_b,
   input  map_pkg::l1_ent_t data_a,
   input  map_pkg::l1_ent_t data_b,
   input  logic             wren_a,
   input  logic             rden_a,
   input  logic             wren_b,
   input  logic             rden_b,
   output map_pkg::l1_ent_t q_a,
   output map_pkg::l1_ent_t q_b
);
   import map_pkg::*;

   l1_ent_t ram [2**L1_IDX_W];

   // one write per edge
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[address_a] <= data_a;
      else if (wren_b)
         ram[address_b] <= data_b; // lost when port a also writes
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[address_a]; // old data on a same-edge write
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= ram[address_b];
   end

endmodule

// File: hw/part_1kx24dpram.sv
/*
 * level-2 map RAM, 1024 x 24
 * two synchronous ports, port a wins a write collision
 * registered reads that hold while rden is low
 */

`timescale 1ns/1ps

module part_1kx24dpram
(
   input  logic             reset,
   input  logic             clk_a,
   input  map_pkg::l2_idx_t address_a,
   input  map_pkg::l2_idx_t address_b,
   input  map_pkg::l2_ent_t data_a,
   input  map_pkg::l2_ent_t data_b,
   input  logic             wren_a,
   input  logic             rden_a,
   input  logic             wren_b,
   input  logic             rden_b,
   output map_pkg::l2_ent_t q_a,
   output map_pkg::l2_ent_t q_b
);
   import map_pkg::*;

   l2_ent_t ram [2**L2_IDX_W];

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[address_a] <= data_a;
      else if (wren_b)
         ram[address_b] <= data_b; // maintenance write dropped on collision
   end

   // read port a, translation side
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[address_a];
   end

   // read port b, maintenance side
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= ram[address_b];
   end

endmodule

// File: hw/map_decode.sv
/*
 * decode stage of the map pipeline
 * channel A drives level-1 port a and registers the stage 1 record
 * channel B drives port b of both maps and records pending reads
 */

`timescale 1ns/1ps

module map_decode
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  map_req_pkg::map_a_req_t  a_req,
   input  map_req_pkg::map_b_req_t  b_req,
   output map_pkg::l1_idx_t         l1_addr_a,
   output map_pkg::l1_ent_t         l1_wdata_a,
   output logic                     l1_wren_a,
   output logic                     l1_rden_a,
   output map_pkg::l1_idx_t         l1_addr_b,
   output map_pkg::l1_ent_t         l1_wdata_b,
   output logic                     l1_wren_b,
   output logic                     l1_rden_b,
   output map_pkg::l2_idx_t         l2_addr_b,
   output map_pkg::l2_ent_t         l2_wdata_b,
   output logic                     l2_wren_b,
   output logic                     l2_rden_b,
   output map_req_pkg::map_s1_t     s1,
   output map_req_pkg::map_b_pend_t b_pend
);
   import map_pkg::*;
   import map_req_pkg::*;

   // channel A, level-1 pointer lookup
   assign l1_addr_a  = a_req.vaddr[L1_FIELD_LSB +: L1_IDX_W];
   assign l1_wdata_a = a_req.wdata[L1_ENT_W-1:0];
   assign l1_wren_a  = a_req.valid && (a_req.op == A_WR_L1);
   assign l1_rden_a  = a_req.valid && (a_req.op == A_XLATE || a_req.op == A_WR_L2);

   // channel B goes straight at either map
   assign l1_addr_b  = b_req.addr;
   assign l1_wdata_b = b_req.wdata[L1_ENT_W-1:0];
   assign l1_wren_b  = b_req.valid && (b_req.op == B_WR_L1);
   assign l1_rden_b  = b_req.valid && (b_req.op == B_RD_L1);

   assign l2_addr_b  = b_req.addr[L2_IDX_W-1:0];
   assign l2_wdata_b = b_req.wdata;
   assign l2_wren_b  = b_req.valid && (b_req.op == B_WR_L2);
   assign l2_rden_b  = b_req.valid && (b_req.op == B_RD_L2);

   always_ff @(posedge clk_a)
   begin
      s1.op    <= a_req.op;
      s1.write <= a_req.write;
      s1.vaddr <= a_req.vaddr;
      s1.wdata <= a_req.wdata;
      if (reset)
         s1.valid <= 1'b0;
      else
         s1.valid <= a_req.valid;
   end

   // only reads expect a response
   always_ff @(posedge clk_a)
   begin
      b_pend.sel_l2 <= l2_rden_b;
      if (reset)
         b_pend.valid <= 1'b0;
      else
         b_pend.valid <= l1_rden_b || l2_rden_b;
   end

endmodule

// File: hw/map_execute.sv
/*
 * execute stage of the map pipeline
 * forms the level-2 index from the level-1 entry and vaddr bits 12..8
 * level-2 read for a translation, level-2 write for A_WR_L2
 */

`timescale 1ns/1ps

module map_execute
(
   input  logic                 clk_a,
   input  logic                 reset,
   input  map_req_pkg::map_s1_t s1,
   input  map_pkg::l1_ent_t     l1_q,
   output map_pkg::l2_idx_t     l2_addr_a,
   output map_pkg::l2_ent_t     l2_wdata_a,
   output logic                 l2_wren_a,
   output logic                 l2_rden_a,
   output map_req_pkg::map_s2_t s2
);
   import map_pkg::*;
   import map_req_pkg::*;

   logic is_xlate;
   logic is_wr_l2;

   assign is_xlate = s1.valid && (s1.op == A_XLATE);
   assign is_wr_l2 = s1.valid && (s1.op == A_WR_L2);

   // level-1 entry selects the block, vaddr picks the entry in it
   assign l2_addr_a  = {l1_q, s1.vaddr[L2_FIELD_LSB +: L2_FIELD_W]};
   assign l2_wdata_a = s1.wdata;
   assign l2_wren_a  = is_wr_l2;
   assign l2_rden_a  = is_xlate;

   always_ff @(posedge clk_a)
   begin
      s2.write  <= s1.write;
      s2.offset <= s1.vaddr[OFFSET_W-1:0];
      if (reset)
         s2.valid <= 1'b0;
      else
         s2.valid <= is_xlate; // writes end here
   end

endmodule

// File: hw/map_result.sv
/*
 * result stage of the map pipeline
 * access check and physical address for translations
 * maintenance read data, level-1 entries zero-extended
 */

`timescale 1ns/1ps

module map_result
(
   input  logic                        clk_a,
   input  logic                        reset,
   input  map_req_pkg::map_s2_t        s2,
   input  map_pkg::l2_ent_t            l2_q_a,
   input  map_req_pkg::map_b_pend_t    b_pend,
   input  map_pkg::l1_ent_t            l1_q_b,
   input  map_pkg::l2_ent_t            l2_q_b,
   output map_req_pkg::map_xlate_rsp_t a_rsp,
   output map_req_pkg::map_b_rsp_t     b_rsp
);
   import map_pkg::*;
   import map_req_pkg::*;

   fault_e  fault;
   page_t   page;
   l2_ent_t b_rdata;

   assign page = l2_q_a[PAGE_W-1:0];

   // invalid takes precedence over write protect
   always_comb
   begin
      if (!l2_q_a[L2_VALID_BIT])
         fault = F_INVALID;
      else if (s2.write && !l2_q_a[L2_WPERM_BIT])
         fault = F_WRITE_PROT;
      else
         fault = F_NONE;
   end

   assign b_rdata = b_pend.sel_l2 ? l2_q_b : {{(L2_ENT_W-L1_ENT_W){1'b0}}, l1_q_b};

   always_ff @(posedge clk_a)
   begin
      a_rsp.fault <= fault;
      a_rsp.paddr <= {page, s2.offset}; // paddr even on a fault
      if (reset)
         a_rsp.valid <= 1'b0;
      else
         a_rsp.valid <= s2.valid;
   end

   always_ff @(posedge clk_a)
   begin
      b_rsp.rdata <= b_rdata;
      if (reset)
         b_rsp.valid <= 1'b0;
      else
         b_rsp.valid <= b_pend.valid;
   end

endmodule

// File: hw/vmem_map.sv
/*
 * virtual memory map top level
 * decode, execute and result stages around the level-1 and level-2 map RAMs
 */

`timescale 1ns/1ps

module vmem_map
(
   input  logic                        clk_a,
   input  logic                        reset,
   input  map_req_pkg::map_a_req_t     a_req,
   input  map_req_pkg::map_b_req_t     b_req,
   output map_req_pkg::map_xlate_rsp_t a_rsp,
   output map_req_pkg::map_b_rsp_t     b_rsp
);
   import map_pkg::*;
   import map_req_pkg::*;

   l1_idx_t     l1_addr_a;
   l1_idx_t     l1_addr_b;
   l1_ent_t     l1_wdata_a;
   l1_ent_t     l1_wdata_b;
   l1_ent_t     l1_q_a;
   l1_ent_t     l1_q_b;
   logic        l1_wren_a;
   logic        l1_rden_a;
   logic        l1_wren_b;
   logic        l1_rden_b;

   l2_idx_t     l2_addr_a;
   l2_idx_t     l2_addr_b;
   l2_ent_t     l2_wdata_a;
   l2_ent_t     l2_wdata_b;
   l2_ent_t     l2_q_a;
   l2_ent_t     l2_q_b;
   logic        l2_wren_a;
   logic        l2_rden_a;
   logic        l2_wren_b;
   logic        l2_rden_b;

   map_s1_t     s1;
   map_s2_t     s2;
   map_b_pend_t b_pend;

   map_decode u_decode
   (
      .clk_a, .reset, .a_req, .b_req,
      .l1_addr_a, .l1_wdata_a, .l1_wren_a, .l1_rden_a,
      .l1_addr_b, .l1_wdata_b, .l1_wren_b, .l1_rden_b,
      .l2_addr_b, .l2_wdata_b, .l2_wren_b, .l2_rden_b,
      .s1, .b_pend
   );

   map_execute u_execute
   (
      .clk_a, .reset, .s1,
      .l1_q       (l1_q_a),
      .l2_addr_a, .l2_wdata_a, .l2_wren_a, .l2_rden_a,
      .s2
   );

   map_result u_result
   (
      .clk_a, .reset, .s2, .l2_q_a, .b_pend, .l1_q_b, .l2_q_b,
      .a_rsp, .b_rsp
   );

   part_2kx5dpram u_l1_map
   (
      .reset, .clk_a,
      .address_a (l1_addr_a),  .address_b (l1_addr_b),
      .data_a    (l1_wdata_a), .data_b    (l1_wdata_b),
      .wren_a    (l1_wren_a),  .rden_a    (l1_rden_a),
      .wren_b    (l1_wren_b),  .rden_b    (l1_rden_b),
      .q_a       (l1_q_a),     .q_b       (l1_q_b)
   );

   part_1kx24dpram u_l2_map
   (
      .reset, .clk_a,
      .address_a (l2_addr_a),  .address_b (l2_addr_b),
      .data_a    (l2_wdata_a), .data_b    (l2_wdata_b),
      .wren_a    (l2_wren_a),  .rden_a    (l2_rden_a),
      .wren_b    (l2_wren_b),  .rden_b    (l2_rden_b),
      .q_a       (l2_q_a),     .q_b       (l2_q_b)
   );

endmodule

// File: sim/vmem_map_sva.sv
/*
 * timing assertions bound to the map top level
 * response latency on both channels, responses quiet in reset
 */

`timescale 1ns/1ps

module vmem_map_sva
(
   input logic                        clk_a,
   input logic                        reset,
   input map_req_pkg::map_a_req_t     a_req,
   input map_req_pkg::map_b_req_t     b_req,
   input map_req_pkg::map_xlate_rsp_t a_rsp,
   input map_req_pkg::map_b_rsp_t     b_rsp
);
   import map_req_pkg::*;

   logic xlate_req;
   logic b_rd_req;
   int   fail_count = 0;

   assign xlate_req = a_req.valid && (a_req.op == A_XLATE);
   assign b_rd_req  = b_req.valid && (b_req.op == B_RD_L1 || b_req.op == B_RD_L2);

   // registered at N+2, seen at the following sample
   a_latency: assert property
      (@(posedge clk_a) disable iff (reset) xlate_req |-> ##3 a_rsp.valid)
   else
   begin
      $error("a_rsp.valid missing 2 edges after a translate request");
      fail_count++;
   end

   a_no_stray: assert property
      (@(posedge clk_a) disable iff (reset) a_rsp.valid |-> $past(xlate_req, 3))
   else
   begin
      $error("a_rsp.valid without a translate request 2 edges before");
      fail_count++;
   end

   b_latency: assert property
      (@(posedge clk_a) disable iff (reset) b_rd_req |-> ##2 b_rsp.valid)
   else
   begin
      $error("b_rsp.valid missing 1 edge after a channel B read");
      fail_count++;
   end

   b_no_stray: assert property
      (@(posedge clk_a) disable iff (reset) b_rsp.valid |-> $past(b_rd_req, 2))
   else
   begin
      $error("b_rsp.valid without a channel B read 1 edge before");
      fail_count++;
   end

   quiet_in_reset: assert property
      (@(posedge clk_a) reset |=> !a_rsp.valid && !b_rsp.valid)
   else
   begin
      $error("response valid while reset is asserted");
      fail_count++;
   end

endmodule

bind vmem_map vmem_map_sva u_vmem_map_sva (.*);

// File: sim/vmem_map_tb.sv
/*
 * testbench for the virtual memory map
 * clock, reset and stimulus on both request channels
 * model of both maps
 * response checks against a queue of due edges
 */

`timescale 1ns/1ps

module vmem_map_tb;
   import map_pkg::*;
   import map_req_pkg::*;

   logic           clk_a = 1'b0;
   logic           reset;
   map_a_req_t     a_req;
   map_b_req_t     b_req;
   map_xlate_rsp_t a_rsp;
   map_b_rsp_t     b_rsp;

   l1_ent_t        l1_model [2**L1_IDX_W];
   l2_ent_t        l2_model [2**L2_IDX_W];
   int             edge_cnt = 0;
   int             a_due [$];
   int             b_due [$];
   map_xlate_rsp_t a_exp [$];
   map_b_rsp_t     b_exp [$];
   int             a_l1_wr_edge = -1;  // edge of the last port a level-1 write
   int             a_l2_wr_edge = -1;  // edge of the last port a level-2 write
   string          test_name = "reset";
   l1_idx_t        blk_idx [4];
   l1_ent_t        blk_ptr [4];

   vmem_map u_vmem_map (.clk_a, .reset, .a_req, .b_req, .a_rsp, .b_rsp);

   always #20 clk_a = ~clk_a;

   always @(posedge clk_a)
      edge_cnt <= edge_cnt + 1;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   // responses settle before the falling edge
   always @(negedge clk_a)
   begin
      if (edge_cnt > 0)
      begin
         if (u_vmem_map.u_vmem_map_sva.fail_count != 0)
            stop_run("a bound timing assertion failed");
         if (a_due.size() > 0 && a_due[0] == edge_cnt)
         begin
            assert (a_rsp == a_exp[0])
               else stop_run($sformatf("[FAIL] %s a_rsp expected %h actual %h",
                                       test_name, a_exp[0], a_rsp));
            void'(a_due.pop_front());
            void'(a_exp.pop_front());
         end
         else
            assert (a_rsp.valid == 1'b0)
               else stop_run($sformatf("[FAIL] %s a_rsp.valid expected 0 actual %b",
                                       test_name, a_rsp.valid));
         if (b_due.size() > 0 && b_due[0] == edge_cnt)
         begin
            assert (b_rsp == b_exp[0])
               else stop_run($sformatf("[FAIL] %s b_rsp expected %h actual %h",
                                       test_name, b_exp[0], b_rsp));
            void'(b_due.pop_front());
            void'(b_exp.pop_front());
         end
         else
            assert (b_rsp.valid == 1'b0)
               else stop_run($sformatf("[FAIL] %s b_rsp.valid expected 0 actual %b",
                                       test_name, b_rsp.valid));
      end
   end

   // fault and physical address from the map model
   function automatic map_xlate_rsp_t expect_xlate(input vaddr_t va, input logic wr);
      l2_ent_t        ent;
      map_xlate_rsp_t rsp;
      ent = l2_model[{l1_model[va[23:13]], va[12:8]}];
      rsp.valid = 1'b1;
      rsp.paddr = {ent[13:0], va[7:0]};
      if (!ent[23])
         rsp.fault = F_INVALID;
      else if (wr && !ent[22])
         rsp.fault = F_WRITE_PROT;
      else
         rsp.fault = F_NONE;
      return rsp;
   endfunction

   task automatic tick();
      @(posedge clk_a);
      a_req.valid <= 1'b0;
      b_req.valid <= 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   // request is sampled one edge after it is driven
   task automatic drive_a(input a_op_e op, input logic wr, input vaddr_t va, input l2_ent_t wd);
      l2_idx_t l2a;
      l2a = {l1_model[va[23:13]], va[12:8]};
      a_req <= '{valid: 1'b1, op: op, write: wr, vaddr: va, wdata: wd};
      case (op)
         A_WR_L1:
         begin
            l1_model[va[23:13]] = wd[4:0];
            a_l1_wr_edge = edge_cnt + 2;
         end
         A_WR_L2:
         begin
            l2_model[l2a] = wd;
            a_l2_wr_edge = edge_cnt + 3;
         end
         default:
         begin
            a_due.push_back(edge_cnt + 4);
            a_exp.push_back(expect_xlate(va, wr));
         end
      endcase
   endtask

   task automatic drive_b(input b_op_e op, input l1_idx_t addr, input l2_ent_t wd);
      map_b_rsp_t rsp;
      b_req <= '{valid: 1'b1, op: op, addr: addr, wdata: wd};
      rsp.valid = 1'b1;
      rsp.rdata = '0;
      case (op)
         B_WR_L1:
            if (edge_cnt + 2 != a_l1_wr_edge)
               l1_model[addr] = wd[4:0];  // lost to a same-edge port a write
         B_WR_L2:
            if (edge_cnt + 2 != a_l2_wr_edge)
               l2_model[addr[9:0]] = wd;  // lost to a same-edge port a write
         default:
         begin
            if (op == B_RD_L2)
               rsp.rdata = l2_model[addr[9:0]];
            else
               rsp.rdata[4:0] = l1_model[addr];
            b_due.push_back(edge_cnt + 3);
            b_exp.push_back(rsp);
         end
      endcase
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      tick();
      while (a_due.size() > 0 || b_due.size() > 0)
      begin
         tick();
         n++;
         if (n > 20)
            stop_run("timeout: responses still outstanding after 20 cycles");
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (reset !== 1'b0)
      begin
         @(posedge clk_a);
         n++;
         if (n > 20)
            stop_run("timeout waiting for reset to be released");
      end
   endtask

   initial
   begin
      int      i;
      int      k;
      int      f;
      vaddr_t  va;
      l2_ent_t wd;
      l1_idx_t addrs [8];
      void'($urandom(59554));
      reset = 1'b1;
      a_req = '0;
      b_req = '0;
      repeat (8) @(posedge clk_a);
      reset <= 1'b0;
      wait_reset_release();
      idle(3);

      test_name = "b_rw";
      for (i = 0; i < 8; i++)
      begin
         addrs[i] = l1_idx_t'($urandom);
         tick();
         drive_b(B_WR_L1, addrs[i], l2_ent_t'($urandom));  // upper bits dropped
         tick();
         drive_b(B_WR_L2, addrs[i], l2_ent_t'($urandom));
      end
      for (i = 0; i < 8; i++)
      begin
         tick();
         drive_b(B_RD_L1, addrs[i], '0);
         tick();
         drive_b(B_RD_L2, addrs[i], '0);
      end
      wait_drain();

      test_name = "a_map_write";
      for (k = 0; k < 4; k++)
      begin
         blk_idx[k] = l1_idx_t'(k * 500 + $urandom_range(0, 499));
         blk_ptr[k] = l1_ent_t'(k * 4 + 1);
         tick();
         drive_a(A_WR_L1, 1'b0, {blk_idx[k], 13'd0}, {19'($urandom), blk_ptr[k]});
         for (f = 0; f < 4; f++)
         begin
            tick();
            drive_a(A_WR_L2, 1'b0, {blk_idx[k], 5'(f), 8'd0},
                    {2'b11, 8'($urandom), 14'($urandom)});
         end
      end
      idle(2);
      for (k = 0; k < 4; k++)
         for (f = 0; f < 4; f++)
         begin
            tick();
            drive_b(B_RD_L2, {1'($urandom), blk_ptr[k], 5'(f)}, '0);
         end
      wait_drain();

      test_name = "xlate";
      for (i = 0; i < 32; i++)
      begin
         k = $urandom_range(0, 3);
         va = {blk_idx[k], 5'($urandom_range(0, 3)), 8'($urandom)};
         tick();
         drive_a(A_XLATE, 1'($urandom), va, '0);
      end
      wait_drain();

      test_name = "fault";
      tick();
      drive_b(B_WR_L2, {1'b0, blk_ptr[0], 5'd4}, {2'b01, 8'($urandom), 14'($urandom)});
      tick();
      drive_b(B_WR_L2, {1'b0, blk_ptr[0], 5'd5}, {2'b10, 8'($urandom), 14'($urandom)});
      for (i = 0; i < 8; i++)
      begin
         tick();
         drive_a(A_XLATE, i[0], {blk_idx[0], 5'(4 + i[1]), 8'($urandom)}, '0);
      end
      wait_drain();

      test_name = "collision";
      wd = {2'b11, 8'($urandom), 14'($urandom)};
      tick();
      drive_a(A_WR_L2, 1'b0, {blk_idx[1], 5'd6, 8'd0}, wd);
      tick();
      drive_b(B_WR_L2, {1'b0, blk_ptr[1], 5'd6}, ~wd);  // same edge as the port a write
      idle(2);
      tick();
      drive_b(B_RD_L2, {1'b0, blk_ptr[1], 5'd6}, '0);
      wait_drain();

      if (u_vmem_map.u_vmem_map_sva.fail_count == 0)
      begin
         $display("TEST OK");
         $finish;
      end
      else
      begin
         $display("bound timing assertions failed %0d times",
                  u_vmem_map.u_vmem_map_sva.fail_count);
         $display("TEST FAILED");
         $fatal(1, "timing assertions failed");
      end
   end

endmodule

// File: vmem_map.f
hw/map_pkg.sv
hw/map_req_pkg.sv
hw/part_2kx5dpram.sv
hw/part_1kx24dpram.sv
hw/map_decode.sv
hw/map_execute.sv
hw/map_result.sv
hw/vmem_map.sv
sim/vmem_map_sva.sv
sim/vmem_map_tb.sv

// File: Bender.yml
package:
  name: vmem_map

sources:
  - files:
      - hw/map_pkg.sv
      - hw/map_req_pkg.sv
      - hw/part_2kx5dpram.sv
      - hw/part_1kx24dpram.sv
      - hw/map_decode.sv
      - hw/map_execute.sv
      - hw/map_result.sv
      - hw/vmem_map.sv
  - target: simulation
    files:
      - sim/vmem_map_sva.sv
      - sim/vmem_map_tb.sv
